// ==== verilog/lc_cfg.svh ====
`ifndef LC_CFG_SVH
`define LC_CFG_SVH

////////////////////
// Sample format
////////////////////

// Width of one I or Q component
`define LC_DATA_W 16

////////////////////
// Chain addressing
////////////////////

// Destination address carried in every packet
`define LC_DEST_W 8

////////////////////
// Sample memory
////////////////////

// Address width and depth of the single-port memory
`define LC_SAMPLE_AW 10
`define LC_DEPTH 1024

`endif

// ==== verilog/lc_sample_pkg.sv ====
`include "lc_cfg.svh"

package lc_sample_pkg;

	////////////////////
	// Data types
	////////////////////

	// Complex sample, I in the upper half
	typedef struct packed {
		logic [`LC_DATA_W-1:0] i;
		logic [`LC_DATA_W-1:0] q;
	} sample_t;

	// Word address into the sample memory
	typedef logic [`LC_SAMPLE_AW-1:0] sample_addr_t;

	// Target controller address
	typedef logic [`LC_DEST_W-1:0] dest_t;

	////////////////////
	// Packet
	////////////////////

	// Destination on top, sample below
	typedef struct packed {
		dest_t   dest;
		sample_t sample;
	} packet_t;

endpackage

// ==== verilog/lc_ctrl_pkg.sv ====
package lc_ctrl_pkg;

	// Tap life cycle
	typedef enum logic [1:0] {
		TAP_IDLE  = 2'd0,
		TAP_ARMED = 2'd1,
		TAP_RUN   = 2'd2
	} tap_state_e;

	// What the memory port does this cycle
	typedef enum logic [1:0] {
		MEM_NOP   = 2'd0,
		MEM_WRITE = 2'd1,
		MEM_READ  = 2'd2
	} mem_op_e;

endpackage

// ==== verilog/tap_config.sv ====
`timescale 1ns/1ps

module tap_config (
	input  logic                       CLK,
	input  logic                       rst_n,
	input  logic                       init,
	input  logic                       from_glob_controller_valid,
	input  lc_sample_pkg::sample_addr_t from_glob_controller_delay,
	input  lc_sample_pkg::dest_t        from_glob_dest_addr,
	input  lc_sample_pkg::dest_t        prev_dest_address,
	output lc_sample_pkg::sample_addr_t tap_delay,
	output lc_sample_pkg::dest_t        dest_address,
	output logic                       cfg_loaded
);

	////////////////////
	// Accept decision
	////////////////////

	logic dest_clash;
	logic cfg_accept;

	// Two controllers in the chain must not share a destination
	assign dest_clash = (from_glob_dest_addr == prev_dest_address);

	// Only inside the init window, and only a valid, clean request
	assign cfg_accept = init && from_glob_controller_valid && !dest_clash;

	////////////////////
	// Config registers
	////////////////////

	// A rejected request leaves the old tap in force
	always_ff @(posedge CLK or negedge rst_n) begin
		if (!rst_n) begin
			tap_delay    <= '0;
			dest_address <= '0;
		end else if (cfg_accept) begin
			tap_delay    <= from_glob_controller_delay;
			dest_address <= from_glob_dest_addr;
		end
	end

	// One-cycle strobe, lines up with the new values
	always_ff @(posedge CLK or negedge rst_n) begin
		if (!rst_n) begin
			cfg_loaded <= 1'b0;
		end else begin
			cfg_loaded <= cfg_accept;
		end
	end

endmodule

// ==== verilog/tap_reader.sv ====
`timescale 1ns/1ps

`include "lc_cfg.svh"

module tap_reader (
	input  logic                        CLK,
	input  logic                        rst_n,
	input  logic                        cfg_loaded,
	input  lc_sample_pkg::sample_addr_t tap_delay,
	input  logic                        input_boundary_flag,
	input  logic                        ceb,
	input  logic                        web,
	input  logic                        write_flag,
	input  lc_sample_pkg::sample_addr_t ext_sample_address,
	output lc_ctrl_pkg::mem_op_e        mem_op,
	output lc_sample_pkg::sample_addr_t rd_address,
	output logic                        rd_first,
	output logic                        rd_issued
);

	lc_ctrl_pkg::tap_state_e     state;
	lc_sample_pkg::sample_addr_t ptr;
	lc_sample_pkg::sample_addr_t issue_addr;
	lc_sample_pkg::sample_addr_t next_addr;
	logic                        first_pend;
	logic                        wr_req;
	logic                        boundary_go;

	////////////////////
	// Port arbitration
	////////////////////

	// ceb and web active low, write_flag active high
	assign wr_req = !ceb && !web && write_flag;

	assign boundary_go = input_boundary_flag &&
		(state == lc_ctrl_pkg::TAP_ARMED || state == lc_ctrl_pkg::TAP_RUN);

	// Frame start reads the delay directly, same cycle
	assign issue_addr = boundary_go ? tap_delay : ptr;

	// Wrap at the end of the frame memory
	assign next_addr = (issue_addr == lc_sample_pkg::sample_addr_t'(`LC_DEPTH - 1)) ?
		'0 : issue_addr + 1'b1;

	// Write wins the port, read stalls
	assign rd_issued = !wr_req && (boundary_go || state == lc_ctrl_pkg::TAP_RUN);
	// first_pend covers a boundary that landed on a write
	assign rd_first  = rd_issued && (boundary_go || first_pend);

	always_comb begin
		if (wr_req) begin
			mem_op     = lc_ctrl_pkg::MEM_WRITE;
			rd_address = ext_sample_address;
		end else begin
			mem_op     = rd_issued ? lc_ctrl_pkg::MEM_READ : lc_ctrl_pkg::MEM_NOP;
			rd_address = issue_addr;
		end
	end

	////////////////////
	// Tap state, frame pointer
	////////////////////

	always_ff @(posedge CLK or negedge rst_n) begin
		if (!rst_n) begin
			state      <= lc_ctrl_pkg::TAP_IDLE;
			ptr        <= '0;
			first_pend <= 1'b0;
		end else if (cfg_loaded) begin
			// New tap, wait for the next boundary
			state      <= lc_ctrl_pkg::TAP_ARMED;
			first_pend <= 1'b0;
		end else if (boundary_go) begin
			state <= lc_ctrl_pkg::TAP_RUN;
			if (wr_req) begin
				ptr        <= tap_delay;
				first_pend <= 1'b1;
			end else begin
				ptr        <= next_addr;
				first_pend <= 1'b0;
			end
		end else if (rd_issued) begin
			ptr        <= next_addr;
			first_pend <= 1'b0;
		end
	end

endmodule

// ==== verilog/sample_ram.sv ====
`timescale 1ns/1ps

`include "lc_cfg.svh"

module sample_ram (
	input  logic                        CLK,
	input  lc_ctrl_pkg::mem_op_e        mem_op,
	input  lc_sample_pkg::sample_addr_t rd_address,
	input  lc_sample_pkg::sample_t      d,
	input  lc_sample_pkg::sample_t      bweb,
	output lc_sample_pkg::sample_t      rd_data
);

	////////////////////
	// Storage
	////////////////////

	// One frame of complex samples
	lc_sample_pkg::sample_t mem [`LC_DEPTH];

	lc_sample_pkg::sample_t wr_merge;

	// bweb low selects d, high keeps the stored bit
	assign wr_merge = (mem[rd_address] & bweb) | (d & ~bweb);

	////////////////////
	// Port
	////////////////////

	// Shared address, one operation per cycle
	always_ff @(posedge CLK) begin
		case (mem_op)
			lc_ctrl_pkg::MEM_WRITE: begin
				mem[rd_address] <= wr_merge;
			end
			lc_ctrl_pkg::MEM_READ: begin
				rd_data <= mem[rd_address];
			end
			default: begin
				// Idle port, read data holds
			end
		endcase
	end

endmodule

// ==== verilog/packet_former.sv ====
`timescale 1ns/1ps

module packet_former (
	input  logic                   CLK,
	input  logic                   rst_n,
	input  logic                   rd_issued,
	input  logic                   rd_first,
	input  lc_sample_pkg::sample_t rd_data,
	input  lc_sample_pkg::dest_t   dest_address,
	output lc_sample_pkg::packet_t packet_out,
	output logic                   packet_valid,
	output logic                   boundary_next
);

	////////////////////
	// Tag alignment
	////////////////////

	logic iss_q;
	logic first_q;

	// Memory read takes one cycle, tags follow it
	always_ff @(posedge CLK or negedge rst_n) begin
		if (!rst_n) begin
			iss_q   <= 1'b0;
			first_q <= 1'b0;
		end else begin
			iss_q   <= rd_issued;
			first_q <= rd_first;
		end
	end

	////////////////////
	// Output register
	////////////////////

	// Zero packet when the slot is empty
	always_ff @(posedge CLK or negedge rst_n) begin
		if (!rst_n) begin
			packet_out    <= '0;
			packet_valid  <= 1'b0;
			boundary_next <= 1'b0;
		end else begin
			packet_valid  <= iss_q;
			boundary_next <= iss_q && first_q;
			if (iss_q) begin
				packet_out.dest   <= dest_address;
				packet_out.sample <= rd_data;
			end else begin
				packet_out <= '0;
			end
		end
	end

endmodule

// ==== verilog/local_controller.sv ====
`timescale 1ns/1ps

module local_controller (
	input  logic                        CLK,
	input  logic                        rst_n,
	// Sample write port
	input  logic                        ceb,
	input  logic                        web,
	input  logic                        write_flag,
	input  lc_sample_pkg::sample_t      d,
	input  lc_sample_pkg::sample_t      bweb,
	input  lc_sample_pkg::sample_addr_t ext_sample_address,
	// From the global controller
	input  logic                        init,
	input  logic                        from_glob_controller_valid,
	input  lc_sample_pkg::sample_addr_t from_glob_controller_delay,
	input  lc_sample_pkg::dest_t        from_glob_dest_addr,
	// Chain neighbours
	input  lc_sample_pkg::dest_t        prev_dest_address,
	input  logic                        input_boundary_flag,
	// Packet stream
	output lc_sample_pkg::packet_t      packet_out,
	output logic                        packet_valid,
	output logic                        boundary_next,
	output lc_sample_pkg::dest_t        dest_address
);

	logic                        cfg_loaded;
	lc_sample_pkg::sample_addr_t tap_delay;
	lc_ctrl_pkg::mem_op_e        mem_op;
	lc_sample_pkg::sample_addr_t rd_address;
	logic                        rd_first;
	logic                        rd_issued;
	lc_sample_pkg::sample_t      rd_data;

	////////////////////
	// Config
	////////////////////

	tap_config u_tap_config (
		.CLK                        (CLK),
		.rst_n                      (rst_n),
		.init                       (init),
		.from_glob_controller_valid (from_glob_controller_valid),
		.from_glob_controller_delay (from_glob_controller_delay),
		.from_glob_dest_addr        (from_glob_dest_addr),
		.prev_dest_address          (prev_dest_address),
		.tap_delay                  (tap_delay),
		.dest_address               (dest_address),
		.cfg_loaded                 (cfg_loaded)
	);

	////////////////////
	// Read pipeline
	////////////////////

	tap_reader u_tap_reader (
		.CLK                 (CLK),
		.rst_n               (rst_n),
		.cfg_loaded          (cfg_loaded),
		.tap_delay           (tap_delay),
		.input_boundary_flag (input_boundary_flag),
		.ceb                 (ceb),
		.web                 (web),
		.write_flag          (write_flag),
		.ext_sample_address  (ext_sample_address),
		.mem_op              (mem_op),
		.rd_address          (rd_address),
		.rd_first            (rd_first),
		.rd_issued           (rd_issued)
	);

	sample_ram u_sample_ram (
		.CLK        (CLK),
		.mem_op     (mem_op),
		.rd_address (rd_address),
		.d          (d),
		.bweb       (bweb),
		.rd_data    (rd_data)
	);

	// Packets leave two cycles after the read
	packet_former u_packet_former (
		.CLK           (CLK),
		.rst_n         (rst_n),
		.rd_issued     (rd_issued),
		.rd_first      (rd_first),
		.rd_data       (rd_data),
		.dest_address  (dest_address),
		.packet_out    (packet_out),
		.packet_valid  (packet_valid),
		.boundary_next (boundary_next)
	);

endmodule

// ==== testbench/local_controller_tb.sv ====
`timescale 1ns/1ps

`include "lc_cfg.svh"

module local_controller_tb;

	localparam int CLK_PERIOD   = 40;
	localparam int RESET_CYCLES = 8;
	localparam int PKT_TIMEOUT  = 20;
	// Reset, full load and stream, masked write, clash, stall
	localparam int TEST_CYCLES  = RESET_CYCLES + (`LC_DEPTH + 60) + 40 + 80 + 70;
	localparam int CYCLE_MARGIN = 200;
	localparam int WATCHDOG_NS  = (TEST_CYCLES + CYCLE_MARGIN) * CLK_PERIOD;
	localparam lc_sample_pkg::dest_t PREV_DEST = 8'h33;

	logic                        clk;
	logic                        rst_n;
	logic                        ceb;
	logic                        web;
	logic                        write_flag;
	lc_sample_pkg::sample_t      d;
	lc_sample_pkg::sample_t      bweb;
	lc_sample_pkg::sample_addr_t ext_sample_address;
	logic                        init;
	logic                        from_glob_controller_valid;
	lc_sample_pkg::sample_addr_t from_glob_controller_delay;
	lc_sample_pkg::dest_t        from_glob_dest_addr;
	lc_sample_pkg::dest_t        prev_dest_address;
	logic                        input_boundary_flag;
	lc_sample_pkg::packet_t      packet_out;
	logic                        packet_valid;
	logic                        boundary_next;
	lc_sample_pkg::dest_t        dest_address;

	// Reference model of memory and tap
	lc_sample_pkg::sample_t      ref_mem [`LC_DEPTH];
	lc_sample_pkg::sample_addr_t exp_delay;
	lc_sample_pkg::dest_t        exp_dest;
	int                          mismatch_count;
	int                          other_count;
	int unsigned                 seed_val;

	local_controller dut0 (
		.CLK                        (clk),
		.rst_n                      (rst_n),
		.ceb                        (ceb),
		.web                        (web),
		.write_flag                 (write_flag),
		.d                          (d),
		.bweb                       (bweb),
		.ext_sample_address         (ext_sample_address),
		.init                       (init),
		.from_glob_controller_valid (from_glob_controller_valid),
		.from_glob_controller_delay (from_glob_controller_delay),
		.from_glob_dest_addr        (from_glob_dest_addr),
		.prev_dest_address          (prev_dest_address),
		.input_boundary_flag        (input_boundary_flag),
		.packet_out                 (packet_out),
		.packet_valid               (packet_valid),
		.boundary_next              (boundary_next),
		.dest_address               (dest_address)
	);

	initial clk = 1'b0;
	always #(CLK_PERIOD / 2) clk = ~clk;

	////////////////////
	// Compare tasks
	////////////////////

	task automatic compare_packet(input string test, input lc_sample_pkg::packet_t expected,
		input lc_sample_pkg::packet_t actual);
		if (actual !== expected) begin
			mismatch_count++;
			$display("mismatch %s: expected %h, actual %h", test, expected, actual);
		end
	endtask

	task automatic compare_dest(input string test, input lc_sample_pkg::dest_t expected,
		input lc_sample_pkg::dest_t actual);
		if (actual !== expected) begin
			mismatch_count++;
			$display("mismatch %s: expected %h, actual %h", test, expected, actual);
		end
	endtask

	task automatic compare_flag(input string test, input logic expected, input logic actual);
		if (actual !== expected) begin
			mismatch_count++;
			$display("mismatch %s: expected %b, actual %b", test, expected, actual);
		end
	endtask

	////////////////////
	// Drivers
	////////////////////

	// Sample and drive point 2 ns past the edge
	task automatic step_cycle();
		@(posedge clk);
		#2;
	endtask

	task automatic idle_cycles(input int n);
		repeat (n) step_cycle();
	endtask

	// Each bit with mask low takes d, the others keep the old word
	task automatic write_word(input lc_sample_pkg::sample_addr_t addr,
		input lc_sample_pkg::sample_t data, input lc_sample_pkg::sample_t mask);
		logic [$bits(lc_sample_pkg::sample_t)-1:0] word;
		logic [$bits(lc_sample_pkg::sample_t)-1:0] dbits;
		logic [$bits(lc_sample_pkg::sample_t)-1:0] mbits;
		word  = ref_mem[addr];
		dbits = data;
		mbits = mask;
		for (int b = 0; b < $bits(lc_sample_pkg::sample_t); b++) begin
			if (mbits[b] == 1'b0) begin
				word[b] = dbits[b];
			end
		end
		ref_mem[addr] = word;
		ceb                = 1'b0;
		web                = 1'b0;
		write_flag         = 1'b1;
		d                  = data;
		bweb               = mask;
		ext_sample_address = addr;
		step_cycle();
	endtask

	task automatic end_write();
		ceb        = 1'b1;
		web        = 1'b1;
		write_flag = 1'b0;
	endtask

	// Tap model only follows a non-clashing destination
	task automatic configure(input lc_sample_pkg::sample_addr_t delay,
		input lc_sample_pkg::dest_t dest);
		if (dest != prev_dest_address) begin
			exp_delay = delay;
			exp_dest  = dest;
		end
		init                       = 1'b1;
		from_glob_controller_valid = 1'b1;
		from_glob_controller_delay = delay;
		from_glob_dest_addr        = dest;
		step_cycle();
		init                       = 1'b0;
		from_glob_controller_valid = 1'b0;
		idle_cycles(2);
	endtask

	task automatic pulse_boundary();
		input_boundary_flag = 1'b1;
		step_cycle();
		input_boundary_flag = 1'b0;
	endtask

	task automatic wait_packet(input string test, input logic need_first, output logic found);
		int n;
		found = 1'b0;
		n     = 0;
		while (!found && n < PKT_TIMEOUT) begin
			if (packet_valid && (boundary_next || !need_first)) begin
				found = 1'b1;
			end else begin
				step_cycle();
				n++;
			end
		end
		if (!found) begin
			other_count++;
			$display("%s: no valid packet arrived within %0d cycles", test, PKT_TIMEOUT);
		end
	endtask

	function automatic lc_sample_pkg::packet_t model_packet(input lc_sample_pkg::dest_t dest,
		input lc_sample_pkg::sample_addr_t addr);
		lc_sample_pkg::packet_t p;
		p.dest   = dest;
		p.sample = ref_mem[addr];
		return p;
	endfunction

	////////////////////
	// Tests
	////////////////////

	task automatic test_reset();
		compare_flag("reset packet_valid", 1'b0, packet_valid);
		compare_flag("reset boundary_next", 1'b0, boundary_next);
		compare_dest("reset dest_address", 8'h00, dest_address);
	endtask

	task automatic test_load_stream();
		lc_sample_pkg::sample_addr_t addr;
		logic found;
		for (int a = 0; a < `LC_DEPTH; a++) begin
			write_word(lc_sample_pkg::sample_addr_t'(a), lc_sample_pkg::sample_t'($urandom), '0);
		end
		end_write();
		configure(10'd1000, 8'd8);
		idle_cycles(2);
		compare_dest("load_stream dest", exp_dest, dest_address);
		pulse_boundary();
		wait_packet("load_stream", 1'b0, found);
		if (found) begin
			compare_flag("load_stream boundary_next", 1'b1, boundary_next);
			// 40 packets that run past address 1023
			for (int k = 0; k < 40; k++) begin
				addr = lc_sample_pkg::sample_addr_t'((1000 + k) % `LC_DEPTH);
				if (!packet_valid) begin
					other_count++;
					$display("load_stream: packet_valid dropped at packet %0d", k);
				end
				compare_packet("load_stream", model_packet(exp_dest, addr), packet_out);
				step_cycle();
			end
		end
	endtask

	task automatic test_masked_write();
		lc_sample_pkg::sample_addr_t addr;
		logic found;
		addr = lc_sample_pkg::sample_addr_t'($urandom_range(0, `LC_DEPTH - 1));
		write_word(addr, lc_sample_pkg::sample_t'($urandom), lc_sample_pkg::sample_t'($urandom));
		end_write();
		configure(addr, 8'h12);
		// Let the old stream drain
		idle_cycles(4);
		compare_dest("masked_write dest", exp_dest, dest_address);
		pulse_boundary();
		wait_packet("masked_write", 1'b1, found);
		if (found) begin
			compare_packet("masked_write", model_packet(exp_dest, addr), packet_out);
		end
	endtask

	task automatic test_dest_clash();
		logic found;
		configure(10'd5, PREV_DEST);
		idle_cycles(2);
		compare_dest("dest_clash rejected", exp_dest, dest_address);
		pulse_boundary();
		wait_packet("dest_clash rejected", 1'b1, found);
		if (found) begin
			compare_packet("dest_clash rejected", model_packet(exp_dest, exp_delay), packet_out);
		end
		configure(10'd300, 8'h21);
		idle_cycles(4);
		compare_dest("dest_clash accepted", exp_dest, dest_address);
		pulse_boundary();
		wait_packet("dest_clash accepted", 1'b1, found);
		if (found) begin
			compare_packet("dest_clash accepted", model_packet(exp_dest, exp_delay), packet_out);
		end
	endtask

	task automatic test_write_stall();
		lc_sample_pkg::sample_addr_t addr;
		int next_k;
		int gaps;
		logic started;
		next_k  = 0;
		gaps    = 0;
		started = 1'b0;
		configure(10'd100, 8'h44);
		idle_cycles(4);
		pulse_boundary();
		for (int c = 0; c < 50; c++) begin
			if (packet_valid) begin
				started = 1'b1;
				addr    = lc_sample_pkg::sample_addr_t'(int'(exp_delay) + next_k);
				compare_packet("write_stall", model_packet(exp_dest, addr), packet_out);
				next_k++;
			end else if (started) begin
				gaps++;
			end
			// Three writes far from the streamed range
			if (c >= 10 && c < 13) begin
				write_word(lc_sample_pkg::sample_addr_t'(890 + c), lc_sample_pkg::sample_t'($urandom),
					'0);
			end else begin
				end_write();
				step_cycle();
			end
		end
		if (next_k == 0) begin
			other_count++;
			$display("write_stall: no packets seen after the boundary");
		end
		if (gaps != 3) begin
			other_count++;
			$display("write_stall: expected 3 empty packet slots, saw %0d", gaps);
		end
	endtask

	////////////////////
	// Main sequence
	////////////////////

	initial begin
		rst_n                      = 1'b0;
		ceb                        = 1'b1;
		web                        = 1'b1;
		write_flag                 = 1'b0;
		d                          = '0;
		bweb                       = '1;
		ext_sample_address         = '0;
		init                       = 1'b0;
		from_glob_controller_valid = 1'b0;
		from_glob_controller_delay = '0;
		from_glob_dest_addr        = '0;
		prev_dest_address          = PREV_DEST;
		input_boundary_flag        = 1'b0;
		exp_delay                  = '0;
		exp_dest                   = '0;
		mismatch_count             = 0;
		other_count                = 0;
		seed_val                   = $urandom(32'hc92b_7564);

		idle_cycles(RESET_CYCLES);
		rst_n = 1'b1;
		step_cycle();

		test_reset();
		test_load_stream();
		test_masked_write();
		test_dest_clash();
		test_write_stall();

		$display("errors: %0d mismatches, %0d other failures", mismatch_count, other_count);
		if (mismatch_count == 0 && other_count == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

	// Watchdog
	initial begin
		#(WATCHDOG_NS);
		$display("watchdog: run did not finish within %0d ns", WATCHDOG_NS);
		$display("TEST FAILED");
		$finish;
	end

endmodule

// ==== src.f ====
+incdir+verilog
verilog/lc_sample_pkg.sv
verilog/lc_ctrl_pkg.sv
verilog/tap_config.sv
verilog/tap_reader.sv
verilog/sample_ram.sv
verilog/packet_former.sv
verilog/local_controller.sv
testbench/local_controller_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Compile with Verilator and run the local controller testbench
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module local_controller_tb \
	-f src.f -o local_controller_sim &&
	./obj_dir/local_controller_sim | tee /dev/stderr | grep "TEST PASSED" > /dev/null &&
	echo "simulation passed" ||
	{ echo "simulation failed"; exit 1; }
